// ==== verilog.f ====
+incdir+testbench
rtl/ds_pkg.sv
rtl/ds_decoder.sv
rtl/ds_gpr_file.sv
rtl/ds_csr_file.sv
rtl/ds_branch_unit.sv
rtl/ds_stage_ctrl.sv
rtl/id_stage.sv
testbench/tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - rtl/ds_pkg.sv
  - rtl/ds_decoder.sv
  - rtl/ds_gpr_file.sv
  - rtl/ds_csr_file.sv
  - rtl/ds_branch_unit.sv
  - rtl/ds_stage_ctrl.sv
  - rtl/id_stage.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_id_stage.sv

// ==== testbench/tb_vectors.svh ====
// step rows; they share register and CSR state, so ecall, csrrw and mret must stay in this order
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// name, wb gpr index (-1 none, data random), wb csr addr (0 none), wb csr data, es_rd,
//   bp cycles, csr addr read; then inst, pc, stall, rd, imm,
//   ctrl {alu_op,use_imm,gpr_wen,mem_ren,mem_wen,mem_op,csr_wen,csr_to_gpr,ebreak,illegal},
//   taken, target, csr_rdata
add_step("addi_unread_src", -1, 12'h000, 64'h0, 5'd5, 0, 12'h000,
         32'h0051_0093, 64'h100, 0, 5'd1, 64'd5, 11'h180, 0, 64'h0, 64'h0);
add_step("add", -1, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'h0020_81B3, 64'h104, 0, 5'd3, 64'd0, 11'h080, 0, 64'h0, 64'h0);
add_step("sub", -1, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'h4062_8233, 64'h108, 0, 5'd4, 64'd0, 11'h280, 0, 64'h0, 64'h0);
add_step("lui", -1, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'h1234_53B7, 64'h10C, 0, 5'd7, 64'h1234_5000, 11'h580, 0, 64'h0, 64'h0);
add_step("lui_neg", -1, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'hFFFF_F3B7, 64'h110, 0, 5'd7, 64'hFFFF_FFFF_FFFF_F000, 11'h580, 0, 64'h0, 64'h0);
add_step("ld", -1, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'hFF84_B403, 64'h114, 0, 5'd8, 64'hFFFF_FFFF_FFFF_FFF8, 11'h1D0, 0, 64'h0, 64'h0);
add_step("sd", -1, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'h00A5_B823, 64'h118, 0, 5'd0, 64'd16, 11'h130, 0, 64'h0, 64'h0);
add_step("add_raw_stall", -1, 12'h000, 64'h0, 5'd2, 0, 12'h000,
         32'h0020_81B3, 64'h11C, 1, 5'd3, 64'd0, 11'h080, 0, 64'h0, 64'h0);
add_step("addi_backpressure", -1, 12'h000, 64'h0, 5'd0, 3, 12'h000,
         32'h0051_0093, 64'h120, 0, 5'd1, 64'd5, 11'h180, 0, 64'h0, 64'h0);
add_step("add_x0_after_write", 0, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'h0000_0633, 64'h124, 0, 5'd12, 64'd0, 11'h080, 0, 64'h0, 64'h0);
add_step("add_after_wb", 20, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'h014A_0AB3, 64'h128, 0, 5'd21, 64'd0, 11'h080, 0, 64'h0, 64'h0);
add_step("beq_taken", -1, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'h0052_8863, 64'h1000, 0, 5'd0, 64'd16, 11'h200, 1, 64'h1010, 64'h0);
add_step("beq_not_taken", -1, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'h0062_8863, 64'h1004, 0, 5'd0, 64'd16, 11'h200, 0, 64'h0, 64'h0);
add_step("bne_back", -1, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'hFE62_9EE3, 64'h2000, 0, 5'd0, 64'hFFFF_FFFF_FFFF_FFFC, 11'h200, 1, 64'h1FFC, 64'h0);
add_step("jal", -1, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'h0010_00EF, 64'h3000, 0, 5'd1, 64'd2048, 11'h080, 1, 64'h3800, 64'h0);
add_step("ecall", -1, 12'h305, 64'h8000_0100, 5'd0, 0, 12'h305,
         32'h0000_0073, 64'h4000, 0, 5'd0, 64'd0, 11'h000, 1, 64'h8000_0100, 64'h8000_0100);
add_step("csrrw_mepc", -1, 12'h000, 64'h0, 5'd0, 0, 12'h341,
         32'h3417_16F3, 64'h8000_0100, 0, 5'd13, 64'd0, 11'h08C, 0, 64'h0, 64'h4000);
add_step("csrrw_mcause", -1, 12'h000, 64'h0, 5'd0, 0, 12'h342,
         32'h3420_1773, 64'h8000_0104, 0, 5'd14, 64'd0, 11'h08C, 0, 64'h0, 64'd11);
add_step("mret", -1, 12'h000, 64'h0, 5'd0, 0, 12'h341,
         32'h3020_0073, 64'h8000_0108, 0, 5'd0, 64'd0, 11'h000, 1, 64'h4000, 64'h4000);
add_step("ebreak", -1, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'h0010_0073, 64'h4004, 0, 5'd0, 64'd0, 11'h002, 0, 64'h0, 64'h0);
add_step("slli_illegal", -1, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'h0010_9093, 64'h4008, 0, 5'd0, 64'd0, 11'h001, 0, 64'h0, 64'h0);
add_step("unknown_word", -1, 12'h000, 64'h0, 5'd0, 0, 12'h000,
         32'hFFFF_FFFF, 64'h400C, 0, 5'd0, 64'd0, 11'h001, 0, 64'h0, 64'h0);

`endif

// ==== testbench/tb_id_stage.sv ====
// table-driven check of id_stage; x1..x31 are preloaded with random data before the steps run
`timescale 1ns/100ps

module tb_id_stage;
  import ds_pkg::*;

  localparam int CLK_HALF = 2;

  typedef struct {
    string             name;
    int                wb_gpr;
    logic [CSR_AW-1:0] wb_csr;
    logic [XLEN-1:0]   wb_cdata;
    logic [GPR_AW-1:0] es_rd;
    int                bp;
    logic [CSR_AW-1:0] csr;
    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   pc;
    logic              stall;
    logic [GPR_AW-1:0] rd;
    logic [XLEN-1:0]   imm;
    logic [10:0]       ctrl;
    logic              taken;
    logic [XLEN-1:0]   target;
    logic [XLEN-1:0]   csr_rd;
  } step_t;

  logic              i_clk, i_rst, i_fs_valid, i_es_allowin;
  fs_to_ds_t         i_fs;
  wb_to_rf_t         i_wb;
  logic [GPR_AW-1:0] i_es_rd, i_ms_rd, i_ws_rd;
  logic [CSR_AW-1:0] i_es_csr, i_ms_csr, i_ws_csr;
  logic              o_ds_allowin, o_es_valid;
  ds_to_es_t         o_es;
  br_bus_t           o_br;

  step_t           steps[$];
  logic [XLEN-1:0] shadow [32]; // expected gpr contents
  int              errors = 0;
  int              checks = 0;

  id_stage dut0 (.*);

  initial begin
    i_clk = 1'b0;
    forever #CLK_HALF i_clk = ~i_clk;
  end

  task automatic add_step(input string name, input int wb_gpr, input logic [CSR_AW-1:0] wb_csr,
                          input logic [XLEN-1:0] wb_cdata, input logic [GPR_AW-1:0] es_rd,
                          input int bp, input logic [CSR_AW-1:0] csr,
                          input logic [INST_W-1:0] inst, input logic [XLEN-1:0] pc,
                          input logic stall, input logic [GPR_AW-1:0] rd,
                          input logic [XLEN-1:0] imm, input logic [10:0] ctrl, input logic taken,
                          input logic [XLEN-1:0] target, input logic [XLEN-1:0] csr_rd);
    steps.push_back('{name, wb_gpr, wb_csr, wb_cdata, es_rd, bp, csr, inst, pc, stall, rd, imm,
                      ctrl, taken, target, csr_rd});
  endtask

  task automatic load_steps();
    `include "tb_vectors.svh"
  endtask

  task automatic check_eq(input string name, input string field, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %s (%s): expected %h, got %h", name, field, exp, got);
    end
  endtask

  // ebreak reads a0 without encoding it
  function automatic logic [GPR_AW-1:0] src1_index(input logic [INST_W-1:0] inst);
    return (inst == 32'h0010_0073) ? 5'd10 : inst[19:15];
  endfunction

  task automatic write_gpr(input logic [GPR_AW-1:0] idx, input logic [XLEN-1:0] data);
    i_wb.gpr_wen  = 1'b1;
    i_wb.gpr_addr = idx;
    i_wb.gpr_data = data;
    @(negedge i_clk);
    i_wb.gpr_wen = 1'b0;
    if (idx != '0) shadow[idx] = data; // x0 stays zero
  endtask

  task automatic write_csr(input logic [CSR_AW-1:0] addr, input logic [XLEN-1:0] data);
    i_wb.csr_wen  = 1'b1;
    i_wb.csr_addr = addr;
    i_wb.csr_data = data;
    @(negedge i_clk);
    i_wb.csr_wen = 1'b0;
  endtask

  task automatic run_step(input step_t s);
    ds_to_es_t held;
    if (s.wb_gpr >= 0) write_gpr(s.wb_gpr[4:0], {$urandom, $urandom});
    if (s.wb_csr != '0) write_csr(s.wb_csr, s.wb_cdata);
    check_eq(s.name, "allowin when empty", 1, o_ds_allowin);
    i_fs_valid   = 1'b1;
    i_fs.inst    = s.inst;
    i_fs.pc      = s.pc;
    i_es_rd      = s.es_rd;
    i_es_allowin = s.stall; // open during a stall so only the hazard holds it
    @(negedge i_clk);
    i_fs_valid = 1'b0;
    if (s.stall) begin
      repeat (3) begin
        check_eq(s.name, "es_valid in stall", 0, o_es_valid);
        check_eq(s.name, "allowin in stall", 0, o_ds_allowin);
        check_eq(s.name, "br taken in stall", 0, o_br.taken);
        @(negedge i_clk);
      end
      i_es_rd      = '0;
      i_es_allowin = 1'b0;
      @(negedge i_clk);
      while (!o_es_valid) @(negedge i_clk);
    end
    held = o_es;
    if (s.bp > 0) begin
      i_fs_valid = 1'b1; // fetch pushes the next packet meanwhile
      i_fs.inst  = ~s.inst;
      i_fs.pc    = s.pc + 64'd4;
    end
    repeat (s.bp) begin
      check_eq(s.name, "es_valid under back-pressure", 1, o_es_valid);
      check_eq(s.name, "allowin under back-pressure", 0, o_ds_allowin);
      checks++;
      assert (o_es === held) else begin
        errors++;
        $display("Fail %s (held packet): expected %h, got %h", s.name, held, o_es);
      end
      @(negedge i_clk);
    end
    i_fs_valid = 1'b0;
    check_eq(s.name, "es_valid", 1, o_es_valid);
    check_eq(s.name, "allowin while held", 0, o_ds_allowin);
    check_eq(s.name, "pc", s.pc, o_es.pc);
    check_eq(s.name, "inst", s.inst, o_es.inst);
    check_eq(s.name, "rd", s.rd, o_es.rd);
    check_eq(s.name, "imm", s.imm, o_es.imm);
    check_eq(s.name, "ctrl", s.ctrl, o_es.ctrl);
    check_eq(s.name, "csr", s.csr, o_es.csr);
    check_eq(s.name, "rs1_data", shadow[src1_index(s.inst)], o_es.rs1_data);
    check_eq(s.name, "rs2_data", shadow[s.inst[24:20]], o_es.rs2_data);
    check_eq(s.name, "csr_rdata", s.csr_rd, o_es.csr_rdata);
    check_eq(s.name, "br taken", s.taken, o_br.taken);
    if (s.taken) check_eq(s.name, "br target", s.target, o_br.target);
    i_es_allowin = 1'b1;
    @(negedge i_clk); // handed to execute on the rising edge
    check_eq(s.name, "es_valid after hand-off", 0, o_es_valid);
    check_eq(s.name, "br taken when empty", 0, o_br.taken);
    i_es_rd = '0;
  endtask

  initial begin
    int limit;
    i_rst        = 1'b1;
    i_fs_valid   = 1'b0;
    i_fs         = '0;
    i_es_allowin = 1'b1;
    i_wb         = '0;
    i_es_rd      = '0;
    i_ms_rd      = '0;
    i_ws_rd      = '0;
    i_es_csr     = '0;
    i_ms_csr     = '0;
    i_ws_csr     = '0;
    void'($urandom(1));
    foreach (shadow[i]) shadow[i] = '0;
    load_steps();
    limit = (steps.size() * 20 + 64) * 2 * CLK_HALF;
    fork
      begin
        #(limit);
        $display("watchdog expired after %0d ns before the step table completed", limit);
        $display("Finished with errors");
        $finish;
      end
    join_none
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    check_eq("reset", "es_valid", 0, o_es_valid);
    check_eq("reset", "br taken", 0, o_br.taken);
    check_eq("reset", "allowin", 1, o_ds_allowin);
    for (int r = 1; r < 32; r++) write_gpr(r[4:0], {$urandom, $urandom});
    foreach (steps[i]) run_step(steps[i]);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== rtl/id_stage.sv ====
// decode stage top; no bypass from write-back, stall logic covers the read-after-write window
`timescale 1ns/100ps

module id_stage (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_fs_valid,
  input  ds_pkg::fs_to_ds_t         i_fs,
  input  logic                      i_es_allowin,
  input  ds_pkg::wb_to_rf_t         i_wb,
  input  logic [ds_pkg::GPR_AW-1:0] i_es_rd,
  input  logic [ds_pkg::GPR_AW-1:0] i_ms_rd,
  input  logic [ds_pkg::GPR_AW-1:0] i_ws_rd,
  input  logic [ds_pkg::CSR_AW-1:0] i_es_csr,
  input  logic [ds_pkg::CSR_AW-1:0] i_ms_csr,
  input  logic [ds_pkg::CSR_AW-1:0] i_ws_csr,
  output logic                      o_ds_allowin,
  output logic                      o_es_valid,
  output ds_pkg::ds_to_es_t         o_es,
  output ds_pkg::br_bus_t           o_br
);
  import ds_pkg::*;

  fs_to_ds_t         ds_inst;
  logic              ds_fire;
  logic [GPR_AW-1:0] rs1, rs2, rd;
  logic              rs1_used, rs2_used, csr_used;
  logic [CSR_AW-1:0] csr;
  logic [XLEN-1:0]   imm, rs1_data, rs2_data, csr_rdata, mtvec, mepc;
  ctrl_t             ctrl;
  br_kind_e          br_kind;
  logic              ecall, mret;

  ds_stage_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_fs_valid   (i_fs_valid),
    .i_fs         (i_fs),
    .i_es_allowin (i_es_allowin),
    .i_rs1_used   (rs1_used),
    .i_rs2_used   (rs2_used),
    .i_csr_used   (csr_used),
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_csr        (csr),
    .i_es_rd      (i_es_rd),
    .i_ms_rd      (i_ms_rd),
    .i_ws_rd      (i_ws_rd),
    .i_es_csr     (i_es_csr),
    .i_ms_csr     (i_ms_csr),
    .i_ws_csr     (i_ws_csr),
    .o_ds_allowin (o_ds_allowin),
    .o_ds_valid   (),
    .o_ds_fire    (ds_fire),
    .o_es_valid   (o_es_valid),
    .o_inst       (ds_inst)
  );

  ds_decoder u_dec (
    .i_inst     (ds_inst.inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (rd),
    .o_rs1_used (rs1_used),
    .o_rs2_used (rs2_used),
    .o_csr_used (csr_used),
    .o_imm      (imm),
    .o_csr      (csr),
    .o_ctrl     (ctrl),
    .o_br_kind  (br_kind),
    .o_ecall    (ecall),
    .o_mret     (mret)
  );

  ds_gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data),
    .i_wen    (i_wb.gpr_wen),
    .i_waddr  (i_wb.gpr_addr),
    .i_wdata  (i_wb.gpr_data)
  );

  ds_csr_file u_csr (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_raddr (csr),
    .o_rdata (csr_rdata),
    .i_wen   (i_wb.csr_wen),
    .i_waddr (i_wb.csr_addr),
    .i_wdata (i_wb.csr_data),
    .i_ecall (ecall && ds_fire), // side effect only on hand-off
    .i_epc   (ds_inst.pc),
    .o_mtvec (mtvec),
    .o_mepc  (mepc)
  );

  ds_branch_unit u_bru (
    .i_br_kind (br_kind),
    .i_ecall   (ecall),
    .i_mret    (mret),
    .i_valid   (o_es_valid),
    .i_pc      (ds_inst.pc),
    .i_imm     (imm),
    .i_rs1data (rs1_data),
    .i_rs2data (rs2_data),
    .i_mtvec   (mtvec),
    .i_mepc    (mepc),
    .o_br      (o_br)
  );

  assign o_es = '{pc: ds_inst.pc, inst: ds_inst.inst, rs1_data: rs1_data, rs2_data: rs2_data,
                  csr_rdata: csr_rdata, imm: imm, rd: rd, csr: csr, ctrl: ctrl};

endmodule

// ==== rtl/ds_stage_ctrl.sv ====
// stage valid and instruction register; stalls on any in-flight gpr/csr destination that is read
`timescale 1ns/100ps

module ds_stage_ctrl (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_fs_valid,
  input  ds_pkg::fs_to_ds_t         i_fs,
  input  logic                      i_es_allowin,
  input  logic                      i_rs1_used,
  input  logic                      i_rs2_used,
  input  logic                      i_csr_used,
  input  logic [ds_pkg::GPR_AW-1:0] i_rs1,
  input  logic [ds_pkg::GPR_AW-1:0] i_rs2,
  input  logic [ds_pkg::CSR_AW-1:0] i_csr,
  input  logic [ds_pkg::GPR_AW-1:0] i_es_rd,
  input  logic [ds_pkg::GPR_AW-1:0] i_ms_rd,
  input  logic [ds_pkg::GPR_AW-1:0] i_ws_rd,
  input  logic [ds_pkg::CSR_AW-1:0] i_es_csr,
  input  logic [ds_pkg::CSR_AW-1:0] i_ms_csr,
  input  logic [ds_pkg::CSR_AW-1:0] i_ws_csr,
  output logic                      o_ds_allowin,
  output logic                      o_ds_valid,
  output logic                      o_ds_fire,
  output logic                      o_es_valid,
  output ds_pkg::fs_to_ds_t         o_inst
);
  import ds_pkg::*;

  logic      ds_valid;
  fs_to_ds_t inst_r;
  logic      hazard;

  function automatic logic gpr_hit(input logic [GPR_AW-1:0] rd);
    return (rd != '0) && ((i_rs1_used && rd == i_rs1) || (i_rs2_used && rd == i_rs2));
  endfunction

  function automatic logic csr_hit(input logic [CSR_AW-1:0] cd);
    return (cd != '0) && i_csr_used && (cd == i_csr);
  endfunction

  assign hazard = gpr_hit(i_es_rd) || gpr_hit(i_ms_rd) || gpr_hit(i_ws_rd)
               || csr_hit(i_es_csr) || csr_hit(i_ms_csr) || csr_hit(i_ws_csr);

  assign o_es_valid   = ds_valid && !hazard;
  assign o_ds_allowin = !ds_valid || (!hazard && i_es_allowin);
  assign o_ds_fire    = o_es_valid && i_es_allowin;
  assign o_ds_valid   = ds_valid;
  assign o_inst       = inst_r;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) inst_r <= i_fs;
  end

  // held packet from fetch is fully known
  a_known_inst: assert property (
    @(posedge i_clk) disable iff (i_rst)
    ds_valid |-> !$isunknown(inst_r)
  );

endmodule

// ==== rtl/ds_branch_unit.sv ====
// redirect select; ecall > mret > branch/jal, taken only when i_valid (stage valid and ready)
`timescale 1ns/100ps

module ds_branch_unit (
  input  ds_pkg::br_kind_e        i_br_kind,
  input  logic                    i_ecall,
  input  logic                    i_mret,
  input  logic                    i_valid,
  input  logic [ds_pkg::XLEN-1:0] i_pc,
  input  logic [ds_pkg::XLEN-1:0] i_imm,
  input  logic [ds_pkg::XLEN-1:0] i_rs1data,
  input  logic [ds_pkg::XLEN-1:0] i_rs2data,
  input  logic [ds_pkg::XLEN-1:0] i_mtvec,
  input  logic [ds_pkg::XLEN-1:0] i_mepc,
  output ds_pkg::br_bus_t         o_br
);
  import ds_pkg::*;

  logic            eq;
  logic            br_cond;
  logic [XLEN-1:0] pc_rel;

  assign eq     = (i_rs1data == i_rs2data);
  assign pc_rel = i_pc + i_imm;

  always_comb begin
    case (i_br_kind)
      BR_BEQ:  br_cond = eq;
      BR_BNE:  br_cond = !eq;
      BR_JAL:  br_cond = 1'b1;
      default: br_cond = 1'b0;
    endcase
  end

  assign o_br.taken  = i_valid && (i_ecall || i_mret || br_cond);
  assign o_br.target = i_ecall ? i_mtvec :
                       i_mret  ? i_mepc  : pc_rel;

endmodule

// ==== rtl/ds_csr_file.sv ====
// mtvec, mepc, mcause only; other addresses read zero and ignore writes; ecall beats a same-edge write
`timescale 1ns/100ps

module ds_csr_file (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic [ds_pkg::CSR_AW-1:0] i_raddr,
  output logic [ds_pkg::XLEN-1:0]   o_rdata,
  input  logic                      i_wen,
  input  logic [ds_pkg::CSR_AW-1:0] i_waddr,
  input  logic [ds_pkg::XLEN-1:0]   i_wdata,
  input  logic                      i_ecall,
  input  logic [ds_pkg::XLEN-1:0]   i_epc,
  output logic [ds_pkg::XLEN-1:0]   o_mtvec,
  output logic [ds_pkg::XLEN-1:0]   o_mepc
);
  import ds_pkg::*;

  logic [XLEN-1:0] mtvec, mepc, mcause;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mtvec  <= '0;
      mepc   <= '0;
      mcause <= '0;
    end else begin
      if (i_wen) begin
        case (i_waddr)
          CSR_MTVEC:  mtvec  <= i_wdata;
          CSR_MEPC:   mepc   <= i_wdata;
          CSR_MCAUSE: mcause <= i_wdata;
          default: ;
        endcase
      end
      if (i_ecall) begin // trap entry
        mepc   <= i_epc;
        mcause <= CAUSE_ECALL_M;
      end
    end
  end

  always_comb begin
    case (i_raddr)
      CSR_MTVEC:  o_rdata = mtvec;
      CSR_MEPC:   o_rdata = mepc;
      CSR_MCAUSE: o_rdata = mcause;
      default:    o_rdata = '0;
    endcase
  end

  assign o_mtvec = mtvec;
  assign o_mepc  = mepc;

  // trap entry from decode and a retiring mepc write must not collide
  a_no_mepc_clash: assert property (
    @(posedge i_clk) disable iff (i_rst)
    !(i_ecall && i_wen && i_waddr == CSR_MEPC)
  );

endmodule

// ==== rtl/ds_gpr_file.sv ====
// 32 x 64 gpr, combinational read, no reset, x0 reads zero; read-during-write returns old data
`timescale 1ns/100ps

module ds_gpr_file (
  input  logic                      i_clk,
  input  logic [ds_pkg::GPR_AW-1:0] i_raddr1,
  input  logic [ds_pkg::GPR_AW-1:0] i_raddr2,
  output logic [ds_pkg::XLEN-1:0]   o_rdata1,
  output logic [ds_pkg::XLEN-1:0]   o_rdata2,
  input  logic                      i_wen,
  input  logic [ds_pkg::GPR_AW-1:0] i_waddr,
  input  logic [ds_pkg::XLEN-1:0]   i_wdata
);
  import ds_pkg::*;

  logic [XLEN-1:0] regs [2**GPR_AW];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // entry 0 is never written
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== rtl/ds_decoder.sv ====
// combinational decode of ADDI ADD SUB LUI LD SD BEQ BNE JAL CSRRW ECALL MRET EBREAK, rest is illegal
`timescale 1ns/100ps

module ds_decoder (
  input  logic [ds_pkg::INST_W-1:0] i_inst,
  output logic [ds_pkg::GPR_AW-1:0] o_rs1,
  output logic [ds_pkg::GPR_AW-1:0] o_rs2,
  output logic [ds_pkg::GPR_AW-1:0] o_rd,
  output logic                      o_rs1_used,
  output logic                      o_rs2_used,
  output logic                      o_csr_used,
  output logic [ds_pkg::XLEN-1:0]   o_imm,
  output logic [ds_pkg::CSR_AW-1:0] o_csr,
  output ds_pkg::ctrl_t             o_ctrl,
  output ds_pkg::br_kind_e          o_br_kind,
  output logic                      o_ecall,
  output logic                      o_mret
);
  import ds_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_ctrl     = '0; // all enables off unless a legal case sets them
    o_rs1      = i_inst[19:15];
    o_rs2      = i_inst[24:20];
    o_rs1_used = 1'b0;
    o_rs2_used = 1'b0;
    o_csr_used = 1'b0;
    o_csr      = '0;
    o_imm      = '0;
    o_br_kind  = BR_NONE;
    o_ecall    = 1'b0;
    o_mret     = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin // addi
          o_rs1_used     = 1'b1;
          o_imm          = imm_i;
          o_ctrl.use_imm = 1'b1;
          o_ctrl.gpr_wen = 1'b1;
        end else o_ctrl.illegal = 1'b1;
      end
      OPC_OP: begin
        if (funct3 == 3'b000 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)) begin
          o_rs1_used     = 1'b1;
          o_rs2_used     = 1'b1;
          o_ctrl.alu_op  = funct7[5] ? ALU_SUB : ALU_ADD;
          o_ctrl.gpr_wen = 1'b1;
        end else o_ctrl.illegal = 1'b1;
      end
      OPC_LUI: begin
        o_imm          = imm_u;
        o_ctrl.alu_op  = ALU_PASS_B;
        o_ctrl.use_imm = 1'b1;
        o_ctrl.gpr_wen = 1'b1;
      end
      OPC_LOAD, OPC_STORE: begin
        if (funct3 == 3'b011) begin // ld / sd only
          o_rs1_used     = 1'b1;
          o_rs2_used     = (opcode == OPC_STORE);
          o_imm          = (opcode == OPC_STORE) ? imm_s : imm_i;
          o_ctrl.use_imm = 1'b1;
          o_ctrl.gpr_wen = (opcode == OPC_LOAD);
          o_ctrl.mem_ren = (opcode == OPC_LOAD);
          o_ctrl.mem_wen = (opcode == OPC_STORE);
          o_ctrl.mem_op  = MEM_D;
        end else o_ctrl.illegal = 1'b1;
      end
      OPC_BRANCH: begin
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          o_rs1_used    = 1'b1;
          o_rs2_used    = 1'b1;
          o_imm         = imm_b;
          o_ctrl.alu_op = ALU_SUB;
          o_br_kind     = funct3[0] ? BR_BNE : BR_BEQ;
        end else o_ctrl.illegal = 1'b1;
      end
      OPC_JAL: begin
        o_imm          = imm_j;
        o_ctrl.gpr_wen = 1'b1; // link value made downstream
        o_br_kind      = BR_JAL;
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b001) begin // csrrw
          o_rs1_used        = 1'b1;
          o_csr_used        = 1'b1;
          o_csr             = i_inst[31:20];
          o_ctrl.csr_wen    = 1'b1;
          o_ctrl.gpr_wen    = 1'b1;
          o_ctrl.csr_to_gpr = 1'b1;
        end else if (i_inst == INST_ECALL) begin
          o_csr_used = 1'b1; // redirect reads mtvec
          o_csr      = CSR_MTVEC;
          o_ecall    = 1'b1;
        end else if (i_inst == INST_MRET) begin
          o_csr_used = 1'b1;
          o_csr      = CSR_MEPC;
          o_mret     = 1'b1;
        end else if (i_inst == INST_EBREAK) begin
          o_rs1         = 5'd10; // a0 carries the exit code
          o_rs1_used    = 1'b1;
          o_ctrl.ebreak = 1'b1;
        end else o_ctrl.illegal = 1'b1;
      end
      default: o_ctrl.illegal = 1'b1;
    endcase
  end

  assign o_rd = o_ctrl.gpr_wen ? i_inst[11:7] : '0;

endmodule

// ==== rtl/ds_pkg.sv ====
// shared types for the decode stage; machine mode only, RV64I subset, no compressed encodings
package ds_pkg;

  localparam int XLEN   = 64;
  localparam int INST_W = 32;
  localparam int GPR_AW = 5;
  localparam int CSR_AW = 12;

  localparam logic [CSR_AW-1:0] CSR_MTVEC  = 12'h305;
  localparam logic [CSR_AW-1:0] CSR_MEPC   = 12'h341;
  localparam logic [CSR_AW-1:0] CSR_MCAUSE = 12'h342;

  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 64'd11; // env call from M-mode

  // major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // full words of the SYSTEM instructions without operands
  localparam logic [INST_W-1:0] INST_ECALL  = 32'h0000_0073;
  localparam logic [INST_W-1:0] INST_EBREAK = 32'h0010_0073;
  localparam logic [INST_W-1:0] INST_MRET   = 32'h3020_0073;

  typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_PASS_B} alu_op_e;
  typedef enum logic {MEM_NONE, MEM_D} mem_op_e;
  typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE, BR_JAL} br_kind_e;

  typedef struct packed {
    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   pc;
  } fs_to_ds_t;

  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;
    logic    gpr_wen;
    logic    mem_ren;
    logic    mem_wen;
    mem_op_e mem_op;
    logic    csr_wen;
    logic    csr_to_gpr; // old csr value goes to rd
    logic    ebreak;
    logic    illegal;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   csr_rdata;
    logic [XLEN-1:0]   imm;
    logic [GPR_AW-1:0] rd;
    logic [CSR_AW-1:0] csr;
    ctrl_t             ctrl;
  } ds_to_es_t;

  typedef struct packed {
    logic              gpr_wen;
    logic [GPR_AW-1:0] gpr_addr;
    logic [XLEN-1:0]   gpr_data;
    logic              csr_wen;
    logic [CSR_AW-1:0] csr_addr;
    logic [XLEN-1:0]   csr_data;
  } wb_to_rf_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } br_bus_t;

endpackage
